/* source/fetch_pkg.sv */
// Fetch front end shared definitions

package fetch_pkg;

  // --------------------
  // Datapath widths
  // --------------------
  // PC and instruction widths
  localparam int XLEN = 32;
  localparam int ILEN = 32;

  // Instructions per memory line
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = ILEN * LINE_WORDS;

  // --------------------
  // Line memory geometry
  // --------------------
  localparam int LINE_DEPTH = 16;
  localparam int LINE_AW    = 4;

  // Byte offset inside a word, word select inside a line
  localparam int OFFSET     = 2;
  localparam int WORD_SEL_W = 2;

  // PCs at or above this byte address fault
  localparam int MEM_BYTES = 256;

  // --------------------
  // Decode flow control
  // --------------------
  // Decode queue slots
  localparam int CREDITS  = 4;
  localparam int CREDIT_W = 3;

  // Fetch fault status sent with each item
  typedef enum logic {
    FaultNone,
    FaultAccess
  } fault_t;

endpackage

/* source/line_mem_if.sv */
// Line memory requester port

`timescale 1ns/1ns

interface line_mem_if;

  // Request side, held until gnt
  logic                         req;
  logic                         we;
  logic [fetch_pkg::LINE_AW-1:0] addr;
  logic [fetch_pkg::LINE_W-1:0]  wdata;

  // Response side
  logic                         gnt;
  logic                         rvalid;
  logic [fetch_pkg::LINE_W-1:0]  rdata;

  // Side that issues accesses
  modport requester (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  // Side that serves accesses, arbiter or memory
  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

/* source/line_memory.sv */
// Synchronous line memory

`timescale 1ns/1ns

module line_memory (
  input  logic        clk_i,
  line_mem_if.arbiter mem
);

  // Line storage, contents undefined until loaded
  logic [fetch_pkg::LINE_W-1:0] lines [fetch_pkg::LINE_DEPTH];

  // Read response registers
  logic                         rvalid_q;
  logic [fetch_pkg::LINE_W-1:0] rdata_q;

  // Single port never stalls
  assign mem.gnt = mem.req;

  // --------------------
  // Write path
  // --------------------
  // Write lands at the grant edge
  always_ff @(posedge clk_i) begin
    if (mem.req && mem.we) begin
      lines[mem.addr] <= mem.wdata;
    end
  end

  // --------------------
  // Read path
  // --------------------
  // One cycle read latency
  always_ff @(posedge clk_i) begin
    if (mem.req && !mem.we) begin
      rdata_q <= lines[mem.addr];
    end
  end

  // Valid pulse follows each granted read
  always_ff @(posedge clk_i) begin
    rvalid_q <= mem.req && !mem.we;
  end

  assign mem.rvalid = rvalid_q;
  assign mem.rdata  = rdata_q;

endmodule

/* source/line_arbiter.sv */
// Two-way line memory arbiter

`timescale 1ns/1ns

module line_arbiter (
  input  logic          clk_i,
  input  logic          rst_n_i,
  line_mem_if.arbiter   load_port,
  line_mem_if.arbiter   fetch_port,
  line_mem_if.requester mem_port
);

  // Loader wins when both ask
  logic pick_load;
  // Owner of the access granted last cycle
  logic owner_load_q;

  assign pick_load = load_port.req;

  // --------------------
  // Request forwarding
  // --------------------
  assign mem_port.req   = load_port.req | fetch_port.req;
  assign mem_port.we    = pick_load ? load_port.we    : fetch_port.we;
  assign mem_port.addr  = pick_load ? load_port.addr  : fetch_port.addr;
  assign mem_port.wdata = pick_load ? load_port.wdata : fetch_port.wdata;

  // At most one grant per cycle
  assign load_port.gnt  = mem_port.gnt & pick_load;
  assign fetch_port.gnt = mem_port.gnt & ~pick_load & fetch_port.req;

  // --------------------
  // Response routing
  // --------------------
  // Remember who was granted for the late rvalid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owner_load_q <= 1'b0;
    end else if (mem_port.gnt) begin
      owner_load_q <= pick_load;
    end
  end

  // Valid goes back to the granted side only
  assign load_port.rvalid  = mem_port.rvalid & owner_load_q;
  assign fetch_port.rvalid = mem_port.rvalid & ~owner_load_q;

  // Data steered the same way, zero elsewhere
  assign load_port.rdata  = owner_load_q ? mem_port.rdata : '0;
  assign fetch_port.rdata = owner_load_q ? '0 : mem_port.rdata;

endmodule

/* source/fetch_controller.sv */
// Fetch sequencing FSM

`timescale 1ns/1ns

module fetch_controller (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,
  input  logic here_i,
  input  logic credit_ok_i,
  input  logic rvalid_i,
  input  logic fault_i,
  output logic req_o,
  output logic issue_o,
  output logic use_fresh_o,
  output logic advance_o
);

  typedef enum logic [2:0] {
    IDLE,
    RUN,
    WAIT_LINE,
    DROP,
    HALT
  } state_t;

  state_t state_q, state_d;

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // Next state, outputs
  // --------------------
  always_comb begin
    state_d     = state_q;
    req_o       = 1'b0;
    issue_o     = 1'b0;
    use_fresh_o = 1'b0;
    advance_o   = 1'b0;
    case (state_q)
      // Wait for the first redirect
      IDLE: begin
        if (flush_i) state_d = RUN;
      end
      RUN: begin
        // Nothing happens in the redirect cycle
        if (!flush_i) begin
          if (fault_i) begin
            // Fault item, then park
            issue_o = credit_ok_i;
            if (credit_ok_i) state_d = HALT;
          end else if (here_i) begin
            issue_o   = credit_ok_i;
            advance_o = credit_ok_i;
          end else begin
            // Miss, launch the line read
            req_o   = 1'b1;
            state_d = WAIT_LINE;
          end
        end
      end
      WAIT_LINE: begin
        if (flush_i) begin
          // Read still outstanding means drop it later
          state_d = rvalid_i ? RUN : DROP;
        end else if (rvalid_i) begin
          use_fresh_o = 1'b1;
          issue_o     = credit_ok_i;
          advance_o   = credit_ok_i;
          state_d     = RUN;
        end
      end
      // Stale read in flight
      DROP: begin
        if (rvalid_i) state_d = RUN;
      end
      HALT: begin
        if (flush_i) state_d = RUN;
      end
      default: state_d = IDLE;
    endcase
  end

endmodule

/* source/instr_sel.sv */
// Line presence check and word select

`timescale 1ns/1ns

module instr_sel (
  input  logic [fetch_pkg::XLEN-1:0]    pc_i,
  input  logic [fetch_pkg::LINE_W-1:0]  line_i,
  input  logic [fetch_pkg::LINE_AW-1:0] line_tag_i,
  input  logic                          line_valid_i,
  input  logic [fetch_pkg::LINE_W-1:0]  fresh_i,
  input  logic                          use_fresh_i,
  output logic                          here_o,
  output logic [fetch_pkg::ILEN-1:0]    instr_o
);

  localparam int SEL_LSB  = fetch_pkg::OFFSET;
  localparam int LINE_LSB = fetch_pkg::OFFSET + fetch_pkg::WORD_SEL_W;

  logic [fetch_pkg::WORD_SEL_W-1:0] word_sel;
  logic [fetch_pkg::LINE_AW-1:0]    pc_line;
  logic [fetch_pkg::LINE_W-1:0]     src_line;

  // PC fields
  assign word_sel = pc_i[SEL_LSB +: fetch_pkg::WORD_SEL_W];
  assign pc_line  = pc_i[LINE_LSB +: fetch_pkg::LINE_AW];

  // Hit when the held line covers the PC
  assign here_o = line_valid_i && (pc_line == line_tag_i);

  // Fresh memory data bypasses the line register
  assign src_line = use_fresh_i ? fresh_i : line_i;
  assign instr_o  = src_line[word_sel*fetch_pkg::ILEN +: fetch_pkg::ILEN];

endmodule

/* source/ifu.sv */
// Instruction fetch unit

`timescale 1ns/1ns

module ifu (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         redirect_i,
  input  logic [fetch_pkg::XLEN-1:0]   redirect_pc_i,
  input  logic                         credit_i,
  line_mem_if.requester                mem,
  output logic                         instr_valid_o,
  output logic [fetch_pkg::ILEN-1:0]   instr_o,
  output logic [fetch_pkg::XLEN-1:0]   instr_pc_o,
  output fetch_pkg::fault_t            instr_fault_o
);

  localparam int LINE_LSB = fetch_pkg::OFFSET + fetch_pkg::WORD_SEL_W;

  logic [fetch_pkg::XLEN-1:0]     pc_q;
  logic [fetch_pkg::LINE_W-1:0]   line_q;
  logic [fetch_pkg::LINE_AW-1:0]  line_tag_q;
  logic                           line_valid_q;
  logic [fetch_pkg::CREDIT_W-1:0] credit_q;
  logic                           req_q;
  logic [fetch_pkg::LINE_AW-1:0]  req_addr_q;

  // Controller and selector wiring
  logic                           here;
  logic                           credit_ok;
  logic                           fault;
  logic                           req;
  logic                           issue;
  logic                           use_fresh;
  logic                           advance;
  logic [fetch_pkg::ILEN-1:0]     sel_instr;

  // --------------------
  // PC and fault
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= '0;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (advance) begin
      pc_q <= pc_q + fetch_pkg::XLEN'(4);
    end
  end

  // Out of range, never sent to memory
  assign fault = pc_q >= fetch_pkg::XLEN'(fetch_pkg::MEM_BYTES);

  // --------------------
  // Line register
  // --------------------
  // Flushed on redirect
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_valid_q <= 1'b0;
    end else if (redirect_i) begin
      line_valid_q <= 1'b0;
    end else if (use_fresh) begin
      line_valid_q <= 1'b1;
    end
  end

  // Line data and tag captured from the fresh read
  always_ff @(posedge clk_i) begin
    if (use_fresh) begin
      line_q     <= mem.rdata;
      line_tag_q <= req_addr_q;
    end
  end

  // --------------------
  // Memory request
  // --------------------
  // Held from launch until granted
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else if (req) begin
      req_q <= 1'b1;
    end else if (mem.gnt) begin
      req_q <= 1'b0;
    end
  end

  // Line address frozen at launch
  always_ff @(posedge clk_i) begin
    if (req) req_addr_q <= pc_q[LINE_LSB +: fetch_pkg::LINE_AW];
  end

  // Fetch side only reads
  assign mem.req   = req_q;
  assign mem.we    = 1'b0;
  assign mem.addr  = req_addr_q;
  assign mem.wdata = '0;

  // --------------------
  // Credits
  // --------------------
  // Redirect leaves credits alone
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= fetch_pkg::CREDIT_W'(fetch_pkg::CREDITS);
    end else begin
      credit_q <= credit_q - fetch_pkg::CREDIT_W'(issue) + fetch_pkg::CREDIT_W'(credit_i);
    end
  end

  assign credit_ok = credit_q != '0;

  fetch_controller i_fetch_controller (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (redirect_i),
    .here_i      (here),
    .credit_ok_i (credit_ok),
    .rvalid_i    (mem.rvalid),
    .fault_i     (fault),
    .req_o       (req),
    .issue_o     (issue),
    .use_fresh_o (use_fresh),
    .advance_o   (advance)
  );

  instr_sel i_instr_sel (
    .pc_i         (pc_q),
    .line_i       (line_q),
    .line_tag_i   (line_tag_q),
    .line_valid_i (line_valid_q),
    .fresh_i      (mem.rdata),
    .use_fresh_i  (use_fresh),
    .here_o       (here),
    .instr_o      (sel_instr)
  );

  // Outputs to decode with a zero word on fault
  assign instr_valid_o = issue;
  assign instr_o       = fault ? '0 : sel_instr;
  assign instr_pc_o    = pc_q;
  assign instr_fault_o = fault ? fetch_pkg::FaultAccess : fetch_pkg::FaultNone;

endmodule

/* source/fetch_top.sv */
// Fetch front end top level

`timescale 1ns/1ns

module fetch_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          redirect_i,
  input  logic [fetch_pkg::XLEN-1:0]    redirect_pc_i,
  input  logic                          credit_i,
  input  logic                          load_valid_i,
  input  logic [fetch_pkg::LINE_AW-1:0] load_addr_i,
  input  logic [fetch_pkg::LINE_W-1:0]  load_data_i,
  output logic                          load_ready_o,
  output logic                          instr_valid_o,
  output logic [fetch_pkg::ILEN-1:0]    instr_o,
  output logic [fetch_pkg::XLEN-1:0]    instr_pc_o,
  output fetch_pkg::fault_t             instr_fault_o
);

  // Loader, fetch and memory side ports
  line_mem_if load_if ();
  line_mem_if fetch_if ();
  line_mem_if mem_if ();

  // --------------------
  // Loader port
  // --------------------
  // Loader only ever writes
  assign load_if.req   = load_valid_i;
  assign load_if.we    = 1'b1;
  assign load_if.addr  = load_addr_i;
  assign load_if.wdata = load_data_i;
  assign load_ready_o  = load_if.gnt;

  ifu i_ifu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .credit_i      (credit_i),
    .mem           (fetch_if.requester),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .instr_fault_o (instr_fault_o)
  );

  line_arbiter i_line_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .load_port  (load_if.arbiter),
    .fetch_port (fetch_if.arbiter),
    .mem_port   (mem_if.requester)
  );

  line_memory i_line_memory (
    .clk_i (clk_i),
    .mem   (mem_if.arbiter)
  );

endmodule

/* bench/fetch_sva.sv */
// Fetch unit credit and memory checks

`timescale 1ns/1ns

module fetch_sva (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input logic [fetch_pkg::CREDIT_W-1:0] count_i,
  input logic                           issue_i,
  input logic                           rvalid_i
);

  // Failure tallies per property
  int bound_fails = 0;
  int rvalid_fails = 0;
  int issue_fails = 0;
  int fail_count;

  assign fail_count = bound_fails + rvalid_fails + issue_fails;

  // --------------------
  // Credit counter
  // --------------------
  // Never above decode queue depth
  credit_bound_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_i <= fetch_pkg::CREDIT_W'(fetch_pkg::CREDITS))
  else begin
    bound_fails++;
    $error("credit counter above decode queue depth");
  end

  // No item without a free slot
  issue_credit_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_i |-> count_i != '0)
  else begin
    issue_fails++;
    $error("instruction issued with zero credits");
  end

  // --------------------
  // Memory handshake
  // --------------------
  // One read in flight, so one-cycle pulses only
  rvalid_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |=> !rvalid_i)
  else begin
    rvalid_fails++;
    $error("rvalid high on two cycles in a row");
  end

endmodule

/* bench/fetch_tb.sv */
// Fetch front end testbench

`timescale 1ns/1ns

module fetch_tb;

  // Expected word and fault for one PC
  typedef struct packed {
    fetch_pkg::fault_t          fault;
    logic [fetch_pkg::ILEN-1:0] word;
  } expect_t;

  logic                          clk_i;
  logic                          rst_n_i;
  logic                          redirect_i;
  logic [fetch_pkg::XLEN-1:0]    redirect_pc_i;
  logic                          credit_i;
  logic                          load_valid_i;
  logic [fetch_pkg::LINE_AW-1:0] load_addr_i;
  logic [fetch_pkg::LINE_W-1:0]  load_data_i;
  logic                          load_ready_o;
  logic                          instr_valid_o;
  logic [fetch_pkg::ILEN-1:0]    instr_o;
  logic [fetch_pkg::XLEN-1:0]    instr_pc_o;
  fetch_pkg::fault_t             instr_fault_o;

  // Copy of every line the loader wrote
  logic [fetch_pkg::LINE_W-1:0] shadow [fetch_pkg::LINE_DEPTH];
  logic [31:0]                  lcg_state;

  // Stream state owned by the comparison process
  logic [fetch_pkg::XLEN-1:0] exp_pc = '0;
  bit                         halted = 1'b1;
  int                         item_count = 0;
  int                         data_errors = 0;
  int                         data_checks = 0;

  // Decode side credit bookkeeping
  int credits_given;
  int credit_limit;

  // Stimulus side tallies
  int flow_errors = 0;
  int flow_checks = 0;
  int sva_fails;

  fetch_top i_fetch_top (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .credit_i      (credit_i),
    .load_valid_i  (load_valid_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .load_ready_o  (load_ready_o),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .instr_fault_o (instr_fault_o)
  );

  bind ifu fetch_sva i_fetch_sva (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .count_i  (credit_q),
    .issue_i  (issue),
    .rvalid_i (mem.rvalid)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [fetch_pkg::LINE_W-1:0] random_line();
    logic [fetch_pkg::LINE_W-1:0] value;
    for (int w = 0; w < fetch_pkg::LINE_WORDS; w++) begin
      value[w*fetch_pkg::ILEN +: fetch_pkg::ILEN] = lcg_next();
    end
    return value;
  endfunction

  // Word at a byte PC, or an access fault past the end of memory
  function automatic expect_t reference_fetch(
    input logic [fetch_pkg::XLEN-1:0]   pc,
    input logic [fetch_pkg::LINE_W-1:0] image [fetch_pkg::LINE_DEPTH]
  );
    expect_t                          res;
    logic [fetch_pkg::LINE_AW-1:0]    line_idx;
    logic [fetch_pkg::WORD_SEL_W-1:0] word_idx;
    res.fault = fetch_pkg::FaultNone;
    res.word  = '0;
    if (pc >= fetch_pkg::XLEN'(fetch_pkg::MEM_BYTES)) begin
      res.fault = fetch_pkg::FaultAccess;
    end else begin
      // Four bytes per word, LINE_WORDS words per line
      line_idx = fetch_pkg::LINE_AW'(pc / fetch_pkg::XLEN'(fetch_pkg::LINE_WORDS * 4));
      word_idx = fetch_pkg::WORD_SEL_W'((pc / 32'd4) % fetch_pkg::XLEN'(fetch_pkg::LINE_WORDS));
      res.word = image[line_idx][word_idx*fetch_pkg::ILEN +: fetch_pkg::ILEN];
    end
    return res;
  endfunction

  // --------------------
  // Comparison process
  // --------------------
  always @(posedge clk_i) begin
    expect_t exp_item;
    if (rst_n_i && instr_valid_o) begin
      exp_item = reference_fetch(exp_pc, shadow);
      data_checks++;
      assert (!halted) else begin
        data_errors++;
        $display("Item at PC %h issued while fetch should be halted", instr_pc_o);
      end
      assert (instr_pc_o == exp_pc) else begin
        data_errors++;
        $display("ERROR t=%0t instr_pc_o got %h expected %h", $time, instr_pc_o, exp_pc);
      end
      assert (instr_o == exp_item.word) else begin
        data_errors++;
        $display("ERROR t=%0t instr_o got %h expected %h", $time, instr_o, exp_item.word);
      end
      assert (instr_fault_o == exp_item.fault) else begin
        data_errors++;
        $display("ERROR t=%0t instr_fault_o got %s expected %s", $time,
                 instr_fault_o.name(), exp_item.fault.name());
      end
      // Fault item ends the stream
      if (exp_item.fault == fetch_pkg::FaultAccess) halted = 1'b1;
      item_count++;
      exp_pc = exp_pc + fetch_pkg::XLEN'(4);
    end
    if (rst_n_i && redirect_i) begin
      assert (!instr_valid_o) else begin
        data_errors++;
        $display("Item issued in the same cycle as a redirect");
      end
      exp_pc = redirect_pc_i;
      halted = 1'b0;
    end
  end

  // Decode model returning a credit per item up to the limit
  initial begin
    credit_i = 1'b0;
    credits_given = 0;
    forever begin
      @(negedge clk_i);
      if (item_count > credits_given && credits_given < credit_limit) begin
        credit_i = 1'b1;
        credits_given++;
      end else begin
        credit_i = 1'b0;
      end
    end
  end

  // Run length bound
  initial begin
    repeat (4000) @(posedge clk_i);
    $display("Watchdog expired after 4000 cycles, stimulus never finished");
    $display("test failed");
    $finish;
  end

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic redirect_to(input logic [fetch_pkg::XLEN-1:0] pc);
    @(negedge clk_i);
    redirect_i = 1'b1;
    redirect_pc_i = pc;
    @(negedge clk_i);
    redirect_i = 1'b0;
  endtask

  // Credit limit for the decode model
  task automatic hold_credits();
    @(posedge clk_i);
    credit_limit = credits_given;
  endtask

  task automatic free_credits();
    @(posedge clk_i);
    credit_limit = 1 << 30;
  endtask

  task automatic return_credit();
    @(posedge clk_i);
    credit_limit = credit_limit + 1;
  endtask

  // Write one line, hold valid until the grant
  task automatic load_line(input logic [fetch_pkg::LINE_AW-1:0] addr,
                           input logic [fetch_pkg::LINE_W-1:0] data);
    int waited;
    bit granted;
    waited = 0;
    granted = 1'b0;
    @(negedge clk_i);
    load_valid_i = 1'b1;
    load_addr_i = addr;
    load_data_i = data;
    while (!granted && waited < 20) begin
      @(posedge clk_i);
      granted = load_ready_o;
      waited++;
    end
    flow_checks++;
    assert (granted) else begin
      flow_errors++;
      $display("load_ready_o never rose for line %0d", addr);
    end
    if (granted) shadow[addr] = data;
    @(negedge clk_i);
    load_valid_i = 1'b0;
  endtask

  task automatic wait_items(input int target, input int limit);
    int waited;
    waited = 0;
    while (item_count < target && waited < limit) begin
      @(negedge clk_i);
      waited++;
    end
    flow_checks++;
    assert (item_count >= target) else begin
      flow_errors++;
      $display("Timed out waiting for %0d items, only %0d arrived", target, item_count);
    end
  endtask

  // Fault item marks the end of a stream
  task automatic wait_halt(input int limit);
    int waited;
    waited = 0;
    while (!halted && waited < limit) begin
      @(negedge clk_i);
      waited++;
    end
    flow_checks++;
    assert (halted) else begin
      flow_errors++;
      $display("Stream never reached its fault item within %0d cycles", limit);
    end
  endtask

  task automatic expect_count(input int target, input string what);
    flow_checks++;
    assert (item_count == target) else begin
      flow_errors++;
      $display("ERROR t=%0t item count got %0d expected %0d in %s", $time, item_count,
               target, what);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int base;
    lcg_state = 32'd44;
    credit_limit = 0;
    rst_n_i = 1'b0;
    redirect_i = 1'b0;
    redirect_pc_i = '0;
    load_valid_i = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Fill the whole memory
    for (int l = 0; l < fetch_pkg::LINE_DEPTH; l++) begin
      load_line(fetch_pkg::LINE_AW'(l), random_line());
    end

    // Full sweep, then the fault at the end of memory
    free_credits();
    base = item_count;
    redirect_to('0);
    wait_halt(400);
    wait_cycles(5);
    expect_count(base + fetch_pkg::LINE_DEPTH * fetch_pkg::LINE_WORDS + 1, "full sweep");

    // Mid-stream redirect to a mid-line target
    base = item_count;
    redirect_to(32'h20);
    wait_items(base + 6, 100);
    redirect_to(32'h88);
    wait_halt(400);

    // Credits held, then handed back one at a time
    wait_cycles(8);
    hold_credits();
    base = item_count;
    redirect_to(32'h40);
    wait_cycles(40);
    expect_count(base + fetch_pkg::CREDITS, "credit stall");
    for (int k = 0; k < 3; k++) begin
      base = item_count;
      return_credit();
      wait_items(base + 1, 30);
      wait_cycles(10);
      expect_count(base + 1, "single credit return");
    end
    free_credits();
    wait_halt(400);

    // Out of range target
    wait_cycles(8);
    base = item_count;
    redirect_to(fetch_pkg::XLEN'(fetch_pkg::MEM_BYTES + 16));
    wait_halt(50);
    wait_cycles(20);
    expect_count(base + 1, "access fault");

    // Loader write while fetch is stalled on credits
    hold_credits();
    base = item_count;
    redirect_to('0);
    wait_items(base + fetch_pkg::CREDITS, 50);
    wait_cycles(10);
    load_line(4'd10, random_line());
    redirect_to(32'hA0);
    free_credits();
    wait_halt(400);
    wait_cycles(5);

    sva_fails = i_fetch_top.i_ifu.i_fetch_sva.fail_count;
    $display("Summary: %0d data checks, %0d flow checks, %0d errors, %0d assertion failures",
             data_checks, flow_checks, data_errors + flow_errors, sva_fails);
    if (data_errors + flow_errors + sva_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* all.f */
source/fetch_pkg.sv
source/line_mem_if.sv
source/line_memory.sv
source/line_arbiter.sv
source/fetch_controller.sv
source/instr_sel.sv
source/ifu.sv
source/fetch_top.sv
bench/fetch_sva.sv
bench/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the fetch front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert --top-module fetch_tb -f all.f -o fetch_sim \
  && ./obj_dir/fetch_sim +verilator+error+limit+100 | tee sim.log \
  || { echo "build or run failed"; exit 1; }

grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
